// ==== design/matmul_params.svh ====
`ifndef MATMUL_PARAMS_SVH
`define MATMUL_PARAMS_SVH

// Array dimension and data widths
`define MM_SIZE          4
`define MM_DWIDTH        8
`define MM_AWIDTH        10
`define MM_STRIDE_WIDTH  8

// Pipeline depths seen by the controller
`define MM_MAC_STAGES    3
`define MM_MEM_LATENCY   1

// The last operand pair enters PE33 after 4N-N-1 cycles, then the MAC adds its depth
`define MM_LATCH_CYCLE   (4 * `MM_SIZE - `MM_SIZE - 1 + `MM_MAC_STAGES)
`define MM_DONE_CYCLE    (`MM_LATCH_CYCLE + `MM_MAC_STAGES)

`endif

// ==== design/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

`include "matmul_params.svh"

    // One matrix element
    typedef logic [`MM_DWIDTH-1:0] word_t;

    // Memory address and the step between consecutive columns or rows
    typedef logic [`MM_AWIDTH-1:0] addr_t;
    typedef logic [`MM_STRIDE_WIDTH-1:0] stride_t;

    // Four words side by side, lane 0 in the low byte
    typedef logic [`MM_SIZE*`MM_DWIDTH-1:0] lane_vec_t;

    // Run cycle count, wide enough for the whole drain
    typedef logic [7:0] cycle_t;

endpackage

`default_nettype wire

// ==== design/operand_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// Four skewed operand lanes, lane k already delayed by k cycles
interface operand_if;

    matmul_pkg::word_t lane0;
    matmul_pkg::word_t lane1;
    matmul_pkg::word_t lane2;
    matmul_pkg::word_t lane3;

    // The fetch unit drives the lanes
    modport source (output lane0, lane1, lane2, lane3);

    // The PE mesh reads them at its edge
    modport sink (input lane0, lane1, lane2, lane3);

endinterface

`default_nettype wire

// ==== design/matmul_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "matmul_params.svh"

module matmul_ctrl
    import matmul_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic start_mat_mul,
    output logic fetch_en,
    output logic skew_clear,
    output logic result_latch,
    output logic done_mat_mul
);

    cycle_t cycle_cnt;

    ////////////////////////////////////////////////////////////////////////////
    // Run counter
    ////////////////////////////////////////////////////////////////////////////

    // The count follows the edges since start rose, so edge n leaves n behind
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            cycle_cnt    <= '0;
            done_mat_mul <= 1'b0;
        end
        else
        begin
            cycle_cnt    <= cycle_cnt + 1'b1;
            // High only for the cycle after the count passes the done value
            done_mat_mul <= (cycle_cnt == cycle_t'(`MM_DONE_CYCLE));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Cycle decodes
    ////////////////////////////////////////////////////////////////////////////

    // One column of A and one row of B are addressed per cycle
    assign fetch_en = (cycle_cnt < cycle_t'(`MM_SIZE));

    assign skew_clear = (cycle_cnt == '0);

    // By this count PE33 has added its last product
    assign result_latch = (cycle_cnt == cycle_t'(`MM_LATCH_CYCLE));

endmodule

`default_nettype wire

// ==== design/operand_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "matmul_params.svh"

module operand_fetch
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  logic      fetch_en,
    input  logic      skew_clear,
    input  addr_t     base,
    input  stride_t   stride,
    input  lane_vec_t rd_data,
    output addr_t     rd_addr,
    operand_if.source lanes
);

    logic   mem_access;
    cycle_t access_cnt;
    logic   data_valid;
    word_t  lane_raw [`MM_SIZE];
    word_t  lane1_d1;
    word_t  lane2_d1;
    word_t  lane2_d2;
    word_t  lane3_d1;
    word_t  lane3_d2;
    word_t  lane3_d3;

    ////////////////////////////////////////////////////////////////////////////
    // Strided address generation
    ////////////////////////////////////////////////////////////////////////////

    // Parked one stride below the base so the first step lands on it
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || !fetch_en)
        begin
            rd_addr    <= base - addr_t'(stride);
            mem_access <= 1'b0;
        end
        else
        begin
            rd_addr    <= rd_addr + addr_t'(stride);
            mem_access <= 1'b1;
        end
    end

    // Counts cycles with an address out, which lags the address by one
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || !mem_access)
            access_cnt <= '0;
        else
            access_cnt <= access_cnt + 1'b1;
    end

    assign data_valid = (access_cnt >= cycle_t'(`MM_MEM_LATENCY));

    ////////////////////////////////////////////////////////////////////////////
    // Lane slicing and skew
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < `MM_SIZE; k++)
            lane_raw[k] = rd_data[k*`MM_DWIDTH +: `MM_DWIDTH] & {`MM_DWIDTH{data_valid}};
    end

    // Lane k waits k cycles so each wavefront meets its partner on the diagonal
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || skew_clear)
        begin
            lane1_d1 <= '0;
            lane2_d1 <= '0;
            lane2_d2 <= '0;
            lane3_d1 <= '0;
            lane3_d2 <= '0;
            lane3_d3 <= '0;
        end
        else
        begin
            lane1_d1 <= lane_raw[1];
            lane2_d1 <= lane_raw[2];
            lane2_d2 <= lane2_d1;
            lane3_d1 <= lane_raw[3];
            lane3_d2 <= lane3_d1;
            lane3_d3 <= lane3_d2;
        end
    end

    assign lanes.lane0 = lane_raw[0];
    assign lanes.lane1 = lane1_d1;
    assign lanes.lane2 = lane2_d2;
    assign lanes.lane3 = lane3_d3;

endmodule

`default_nettype wire

// ==== design/processing_element.sv ====
`timescale 1ns/10ps
`default_nettype none

module processing_element
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  clear,
    input  word_t in_a,
    input  word_t in_b,
    output word_t out_a,
    output word_t out_b,
    output word_t out_c
);

    word_t product;

    // The forwarding registers double as the first MAC stage
    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            out_a   <= '0;
            out_b   <= '0;
            product <= '0;
            out_c   <= '0;
        end
        else
        begin
            out_a   <= in_a;
            out_b   <= in_b;
            // Only the low byte is kept, so the sum wraps modulo 256
            product <= out_a * out_b;
            out_c   <= out_c + product;
        end
    end

endmodule

`default_nettype wire

// ==== design/pe_array.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "matmul_params.svh"

module pe_array
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pe_reset,
    operand_if.sink   a_lanes,
    operand_if.sink   b_lanes,
    output lane_vec_t result_col0,
    output lane_vec_t result_col1,
    output lane_vec_t result_col2,
    output lane_vec_t result_col3
);

    logic      pe_clear;
    word_t     a_fwd [`MM_SIZE][`MM_SIZE+1];
    word_t     b_fwd [`MM_SIZE+1][`MM_SIZE];
    word_t     acc   [`MM_SIZE][`MM_SIZE];
    lane_vec_t col_pack [`MM_SIZE];

    // Accumulators survive a dropped start and clear only here
    assign pe_clear = reset | pe_reset;

    // A rows enter column 0 from the left and B columns enter row 0 from the top
    assign a_fwd[0][0] = a_lanes.lane0;
    assign a_fwd[1][0] = a_lanes.lane1;
    assign a_fwd[2][0] = a_lanes.lane2;
    assign a_fwd[3][0] = a_lanes.lane3;
    assign b_fwd[0][0] = b_lanes.lane0;
    assign b_fwd[0][1] = b_lanes.lane1;
    assign b_fwd[0][2] = b_lanes.lane2;
    assign b_fwd[0][3] = b_lanes.lane3;

    ////////////////////////////////////////////////////////////////////////////
    // Mesh where PE(i,j) computes C[i][j]
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `MM_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < `MM_SIZE; j++)
        begin : g_col
            processing_element pe (
                .clk   (clk),
                .clear (pe_clear),
                .in_a  (a_fwd[i][j]),
                .in_b  (b_fwd[i][j]),
                .out_a (a_fwd[i][j+1]),
                .out_b (b_fwd[i+1][j]),
                .out_c (acc[i][j])
            );
        end
    end

    // Row i of each column goes to lane i
    always_comb
    begin
        for (int j = 0; j < `MM_SIZE; j++)
            for (int i = 0; i < `MM_SIZE; i++)
                col_pack[j][i*`MM_DWIDTH +: `MM_DWIDTH] = acc[i][j];
    end

    assign result_col0 = col_pack[0];
    assign result_col1 = col_pack[1];
    assign result_col2 = col_pack[2];
    assign result_col3 = col_pack[3];

endmodule

`default_nettype wire

// ==== design/result_drain.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_drain
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  logic      result_latch,
    input  logic      done_mat_mul,
    input  lane_vec_t result_col0,
    input  lane_vec_t result_col1,
    input  lane_vec_t result_col2,
    input  lane_vec_t result_col3,
    input  addr_t     base,
    input  stride_t   stride,
    output lane_vec_t c_data_out,
    output addr_t     c_addr,
    output logic      c_data_available
);

    // Columns 1 to 3 wait here while column 0 is on the output
    lane_vec_t queue_1;
    lane_vec_t queue_2;
    lane_vec_t queue_3;

    ////////////////////////////////////////////////////////////////////////////
    // Capture and shift out
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || done_mat_mul)
        begin
            // Done coincides with word 3, so the next edge ends the drain
            c_data_available <= 1'b0;
            c_addr           <= base - addr_t'(stride);
            c_data_out       <= '0;
            queue_1          <= '0;
            queue_2          <= '0;
            queue_3          <= '0;
        end
        else if (result_latch)
        begin
            c_data_available <= 1'b1;
            c_addr           <= c_addr + addr_t'(stride);
            c_data_out       <= result_col0;
            queue_1          <= result_col1;
            queue_2          <= result_col2;
            queue_3          <= result_col3;
        end
        else if (c_data_available)
        begin
            c_addr     <= c_addr + addr_t'(stride);
            c_data_out <= queue_1;
            queue_1    <= queue_2;
            queue_2    <= queue_3;
            queue_3    <= '0;    // nothing behind column 3
        end
    end

endmodule

`default_nettype wire

// ==== design/matmul_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module matmul_top
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      pe_reset,
    input  logic      start_mat_mul,
    input  addr_t     address_mat_a,
    input  addr_t     address_mat_b,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_a,
    input  stride_t   address_stride_b,
    input  stride_t   address_stride_c,
    input  lane_vec_t a_data,
    input  lane_vec_t b_data,
    output addr_t     a_addr,
    output addr_t     b_addr,
    output addr_t     c_addr,
    output lane_vec_t c_data_out,
    output logic      c_data_available,
    output logic      done_mat_mul
);

    logic      fetch_en;
    logic      skew_clear;
    logic      result_latch;
    lane_vec_t result_col0;
    lane_vec_t result_col1;
    lane_vec_t result_col2;
    lane_vec_t result_col3;

    operand_if a_lanes ();
    operand_if b_lanes ();

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    matmul_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .fetch_en      (fetch_en),
        .skew_clear    (skew_clear),
        .result_latch  (result_latch),
        .done_mat_mul  (done_mat_mul)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Operand fetch, A lanes are rows and B lanes are columns
    ////////////////////////////////////////////////////////////////////////////

    operand_fetch u_fetch_a (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .fetch_en      (fetch_en),
        .skew_clear    (skew_clear),
        .base          (address_mat_a),
        .stride        (address_stride_a),
        .rd_data       (a_data),
        .rd_addr       (a_addr),
        .lanes         (a_lanes)
    );

    operand_fetch u_fetch_b (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .fetch_en      (fetch_en),
        .skew_clear    (skew_clear),
        .base          (address_mat_b),
        .stride        (address_stride_b),
        .rd_data       (b_data),
        .rd_addr       (b_addr),
        .lanes         (b_lanes)
    );

    pe_array u_array (
        .clk         (clk),
        .reset       (reset),
        .pe_reset    (pe_reset),
        .a_lanes     (a_lanes),
        .b_lanes     (b_lanes),
        .result_col0 (result_col0),
        .result_col1 (result_col1),
        .result_col2 (result_col2),
        .result_col3 (result_col3)
    );

    result_drain u_drain (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .result_latch     (result_latch),
        .done_mat_mul     (done_mat_mul),
        .result_col0      (result_col0),
        .result_col1      (result_col1),
        .result_col2      (result_col2),
        .result_col3      (result_col3),
        .base             (address_mat_c),
        .stride           (address_stride_c),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

`default_nettype wire

// ==== verification/matmul_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "matmul_params.svh"

module matmul_checker
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  addr_t     address_mat_a,
    input  addr_t     address_mat_b,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_a,
    input  stride_t   address_stride_b,
    input  stride_t   address_stride_c,
    input  addr_t     a_addr,
    input  addr_t     b_addr,
    input  addr_t     c_addr,
    input  lane_vec_t c_data_out,
    input  logic      c_data_available,
    input  logic      done_mat_mul,
    input  int        test_id,
    input  lane_vec_t exp_cols [`MM_SIZE],
    output int        tests_passed,
    output int        tests_failed,
    output int        error_count
);

    // Word 0 appears after edge 15 from start and done rides with word 3
    localparam int FIRST_WORD_EDGE = 15;
    localparam int DONE_EDGE       = 18;

    int edges;
    int words_seen;
    int done_seen;
    int errors_at_start;

    task automatic compare(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (expv !== actv)
        begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expv, actv);
            error_count++;
        end
    endtask

    // Address k steps from the base, wrapping at the address width
    function automatic addr_t strided_addr(
        input addr_t   base,
        input stride_t stride,
        input int      k
    );
        return base + addr_t'(k) * addr_t'(stride);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks on the state left behind by edge e
    ////////////////////////////////////////////////////////////////////////////

    task automatic fetch_addr_check(input int e);
        if (e >= 1 && e <= `MM_SIZE)
        begin
            compare("a_addr", 32'(strided_addr(address_mat_a, address_stride_a, e - 1)),
                    32'(a_addr));
            compare("b_addr", 32'(strided_addr(address_mat_b, address_stride_b, e - 1)),
                    32'(b_addr));
        end
        else if (e == `MM_SIZE + 1)
        begin
            compare("a_addr", 32'(strided_addr(address_mat_a, address_stride_a, -1)),
                    32'(a_addr));
            compare("b_addr", 32'(strided_addr(address_mat_b, address_stride_b, -1)),
                    32'(b_addr));
        end
    endtask

    task automatic drain_check(input int e);
        int   j;
        logic exp_avail;
        exp_avail = (e >= FIRST_WORD_EDGE && e <= DONE_EDGE);
        compare("c_data_available", 32'(exp_avail), 32'(c_data_available));
        compare("done_mat_mul", 32'(e == DONE_EDGE), 32'(done_mat_mul));
        if (exp_avail)
        begin
            j = e - FIRST_WORD_EDGE;
            compare("c_data_out", exp_cols[j], c_data_out);
            compare("c_addr", 32'(strided_addr(address_mat_c, address_stride_c, j)),
                    32'(c_addr));
        end
        if (c_data_available)
            words_seen++;
        if (done_mat_mul)
            done_seen++;
    endtask

    task automatic idle_check();
        compare("c_data_available", 32'h0, 32'(c_data_available));
        compare("done_mat_mul", 32'h0, 32'(done_mat_mul));
        compare("c_data_out", 32'h0, c_data_out);
    endtask

    task automatic finish_test();
        if (words_seen != `MM_SIZE)
        begin
            $display("test %0d: expected four result words but saw %0d", test_id, words_seen);
            error_count++;
        end
        if (done_seen != 1)
        begin
            $display("test %0d: done_mat_mul was high for %0d cycles", test_id, done_seen);
            error_count++;
        end
        if (error_count == errors_at_start)
        begin
            $display("test %0d: passed", test_id);
            tests_passed++;
        end
        else
        begin
            $display("test %0d: failed with %0d errors", test_id, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    // Outputs are all registered, so the posedge sees the previous edge's state
    always @(posedge clk)
    begin
        if (reset)
        begin
            edges        = 0;
            tests_passed = 0;
            tests_failed = 0;
            error_count  = 0;
        end
        else if (start_mat_mul)
        begin
            if (edges == 0)
            begin
                errors_at_start = error_count;
                words_seen      = 0;
                done_seen       = 0;
            end
            fetch_addr_check(edges);
            drain_check(edges);
            edges++;
        end
        else
        begin
            if (edges > 0)
                finish_test();
            edges = 0;
            idle_check();
        end
    end

endmodule

`default_nettype wire

// ==== verification/matmul_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "matmul_params.svh"

module matmul_tb
    import matmul_pkg::*;
;

    localparam int NUM_TESTS        = 5;
    localparam int FIELDS_PER_TEST  = 55;
    localparam int DONE_WAIT_CYCLES = 30;
    localparam int WATCHDOG_NS      = NUM_TESTS * 30 * 8 * 2;

    logic      clk = 1'b0;
    logic      reset;
    logic      pe_reset;
    logic      start_mat_mul;
    addr_t     address_mat_a;
    addr_t     address_mat_b;
    addr_t     address_mat_c;
    stride_t   address_stride_a;
    stride_t   address_stride_b;
    stride_t   address_stride_c;
    lane_vec_t a_data = '0;
    lane_vec_t b_data = '0;
    addr_t     a_addr;
    addr_t     b_addr;
    addr_t     c_addr;
    lane_vec_t c_data_out;
    logic      c_data_available;
    logic      done_mat_mul;

    addr_t       a_addr_q = '0;
    addr_t       b_addr_q = '0;
    lane_vec_t   mem_a [1024];
    lane_vec_t   mem_b [1024];
    logic [15:0] pmem [512];
    lane_vec_t   exp_cols [`MM_SIZE];
    int          test_id;
    int          tb_errors;
    int          tests_passed;
    int          tests_failed;
    int          error_count;
    integer      seed;

    always #4 clk = ~clk;

    matmul_top matmul_top_i (.*);

    matmul_checker u_checker (.*);

    ////////////////////////////////////////////////////////////////////////////
    // Memory model with one cycle of read latency
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        a_addr_q <= a_addr;
        b_addr_q <= b_addr;
    end

    // Data for the address taken at the last edge is in place before the next one
    always @(negedge clk)
    begin
        a_data <= mem_a[a_addr_q];
        b_data <= mem_b[b_addr_q];
    end

    function automatic logic [15:0] pattern_field(input int t, input int n);
        return pmem[t * FIELDS_PER_TEST + n];
    endfunction

    // Columns of A and rows of B go to memory and columns of C become expected words
    task automatic load_test(input int t, output logic pe_flag);
        lane_vec_t word;
        address_mat_a    = addr_t'(pattern_field(t, 0));
        address_mat_b    = addr_t'(pattern_field(t, 1));
        address_mat_c    = addr_t'(pattern_field(t, 2));
        address_stride_a = stride_t'(pattern_field(t, 3));
        address_stride_b = stride_t'(pattern_field(t, 4));
        address_stride_c = stride_t'(pattern_field(t, 5));
        pe_flag          = (pattern_field(t, 6) != 16'h0);
        for (int k = 0; k < `MM_SIZE; k++)
        begin
            for (int i = 0; i < `MM_SIZE; i++)
                word[i*`MM_DWIDTH +: `MM_DWIDTH] = word_t'(pattern_field(t, 7 + i*4 + k));
            mem_a[address_mat_a + addr_t'(k) * addr_t'(address_stride_a)] = word;
            for (int j = 0; j < `MM_SIZE; j++)
                word[j*`MM_DWIDTH +: `MM_DWIDTH] = word_t'(pattern_field(t, 23 + k*4 + j));
            mem_b[address_mat_b + addr_t'(k) * addr_t'(address_stride_b)] = word;
        end
        for (int j = 0; j < `MM_SIZE; j++)
        begin
            for (int i = 0; i < `MM_SIZE; i++)
                word[i*`MM_DWIDTH +: `MM_DWIDTH] = word_t'(pattern_field(t, 39 + i*4 + j));
            exp_cols[j] = word;
        end
    endtask

    task automatic run_test(input int t);
        logic pe_flag;
        int   gap;
        int   waited;
        @(negedge clk);
        load_test(t, pe_flag);
        if (pe_flag)
        begin
            @(negedge clk);
            pe_reset = 1'b1;
            @(negedge clk);
            pe_reset = 1'b0;
        end
        gap = int'($unsigned($random(seed)) % 32'd4) + 1;
        repeat (gap) @(negedge clk);
        test_id       = t;
        start_mat_mul = 1'b1;
        waited        = 0;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!done_mat_mul && waited < DONE_WAIT_CYCLES);
        if (!done_mat_mul)
        begin
            $display("test %0d: done_mat_mul did not rise within %0d cycles", t, waited);
            tb_errors++;
        end
        // Word 3 is out and the next edge ends the drain
        @(negedge clk);
        start_mat_mul = 1'b0;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog: the run timed out after %0d ns", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        seed             = 32'h441f332a;
        reset            = 1'b1;
        pe_reset         = 1'b0;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = '0;
        address_stride_b = '0;
        address_stride_c = '0;
        test_id          = 0;
        tb_errors        = 0;
        for (int n = 0; n < 512; n++)
            pmem[n] = 16'hf000 | 16'(n);
        for (int a = 0; a < 1024; a++)
        begin
            mem_a[a] = lane_vec_t'(32'(a) * 32'h9e3779b1);
            mem_b[a] = lane_vec_t'(32'(a) * 32'h85ebca6b);
        end
        for (int j = 0; j < `MM_SIZE; j++)
            exp_cols[j] = '0;
        $readmemh("verification/matmul_patterns.txt", pmem);
        repeat (5) @(negedge clk);
        reset = 1'b0;
        if (pmem[NUM_TESTS * FIELDS_PER_TEST - 1] ==
            (16'hf000 | 16'(NUM_TESTS * FIELDS_PER_TEST - 1)))
        begin
            $display("The pattern file holds fewer than %0d tests", NUM_TESTS);
            tb_errors++;
        end
        else
        begin
            for (int t = 0; t < NUM_TESTS; t++)
                run_test(t);
        end
        repeat (2) @(negedge clk);
        $display("Tests passed %0d, tests failed %0d, mismatches %0d, other errors %0d",
                 tests_passed, tests_failed, error_count, tb_errors);
        if (tb_errors == 0 && error_count == 0 && tests_passed == NUM_TESTS)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/matmul_patterns.txt ====
// Line 1: base_a base_b base_c stride_a stride_b stride_c pe_reset, then A row-major
// Line 2: B row-major, then expected C row-major (modulo 256)
000 100 200 01 01 01 1 01 02 03 04 10 20 30 40 55 66 77 88 F0 E1 D2 C3
00 03 00 00 00 00 03 00 00 00 00 03 03 00 00 00 0C 03 06 09 C0 30 60 90 98 FF 32 65 49 D0 A3 76
0F0 3F8 123 07 05 40 1 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10
01 00 02 01 00 01 01 02 02 01 00 01 01 02 01 00 0B 0D 08 08 1B 1D 18 18 2B 2D 28 28 3B 3D 38 38
010 011 3F0 20 20 08 0 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10
01 00 02 01 00 01 01 02 02 01 00 01 01 02 01 00 16 1A 10 10 36 3A 30 30 56 5A 50 50 76 7A 70 70
3FE 100 000 01 03 01 0 01 02 03 04 10 20 30 40 55 66 77 88 F0 E1 D2 C3
00 03 00 00 00 00 03 00 00 00 00 03 03 00 00 00 22 1D 16 19 F6 6A 90 C0 EE 59 82 B5 BF 4A 13 E6
155 2AA 300 FF 80 FF 1 FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF
FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04 04

// ==== tb.f ====
+incdir+design
design/matmul_pkg.sv
design/operand_if.sv
design/matmul_ctrl.sv
design/operand_fetch.sv
design/processing_element.sv
design/pe_array.sv
design/result_drain.sv
design/matmul_top.sv
verification/matmul_checker.sv
verification/matmul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module matmul_tb -o matmul_sim --Mdir obj_dir

./obj_dir/matmul_sim > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
